//--- sdram_pkg.sv
package sdram_pkg;

   // Port count and address split
   localparam int NUM_PORTS = 2;
   localparam int COL_W = 8;
   localparam int ROW_W = 13;
   localparam int BANK_W = 2;

   // SDRAM timing in clock cycles
   localparam int CAS_LATENCY = 2;
   localparam int T_RCD = 2;
   localparam int T_RP = 2;
   localparam int T_RFC = 7;
   localparam int REF_INTERVAL = 390;
   // Power-up delay, short for simulation
   localparam int INIT_WAIT = 20;

   localparam int WAIT_W = $clog2(INIT_WAIT + 1);
   localparam int REF_CNT_W = $clog2(REF_INTERVAL + 1);

   typedef logic [29:0] wb_adr_t;
   typedef logic [31:0] wb_dat_t;
   typedef logic [3:0]  wb_sel_t;
   typedef logic        port_id_t;

   typedef logic [15:0] sdram_dq_t;
   typedef logic [12:0] sdram_adr_t;
   typedef logic [BANK_W-1:0] sdram_ba_t;
   typedef logic [1:0]  sdram_dqm_t;

   typedef logic [WAIT_W-1:0]    wait_cnt_t;
   typedef logic [REF_CNT_W-1:0] ref_cnt_t;

   // Bits are cs_n, ras_n, cas_n, we_n
   typedef enum logic [3:0] {
      CMD_LMR   = 4'b0000,
      CMD_REF   = 4'b0001,
      CMD_PRE   = 4'b0010,
      CMD_ACT   = 4'b0011,
      CMD_WRITE = 4'b0100,
      CMD_READ  = 4'b0101,
      CMD_NOP   = 4'b0111
   } sdram_cmd_e;

   // Burst length 1, sequential, CAS latency from above
   localparam sdram_adr_t MODE_WORD = {6'b000000, 3'(CAS_LATENCY), 1'b0, 3'b000};

   typedef struct packed {
      wb_adr_t adr;
      logic    we;
      wb_dat_t dat;
      wb_sel_t sel;
   } mem_req_t;

   typedef struct packed {
      sdram_cmd_e cmd;
      sdram_ba_t  ba;
      sdram_adr_t a;
      sdram_dqm_t dqm;
      logic       dq_oe;
      sdram_dq_t  dq_out;
   } sdram_pads_t;

   localparam sdram_pads_t PADS_IDLE = '{
      cmd: CMD_NOP, ba: '0, a: '0, dqm: '0, dq_oe: 1'b0, dq_out: '0
   };

endpackage

//--- wb_port_arbiter.sv
`timescale 1ns/1ns

module wb_port_arbiter import sdram_pkg::*; (
   input  logic                    sdram_clk_0,
   input  logic                    wb_rst,
   input  logic    [NUM_PORTS-1:0] wbs_cyc_i,
   input  logic    [NUM_PORTS-1:0] wbs_stb_i,
   input  logic    [NUM_PORTS-1:0] wbs_we_i,
   input  wb_adr_t [NUM_PORTS-1:0] wbs_adr_i,
   input  wb_dat_t [NUM_PORTS-1:0] wbs_dat_i,
   input  wb_sel_t [NUM_PORTS-1:0] wbs_sel_i,
   output logic    [NUM_PORTS-1:0] wbs_ack_o,
   output wb_dat_t [NUM_PORTS-1:0] wbs_dat_o,
   output mem_req_t                req_o,
   output logic                    req_valid_o,
   input  logic                    req_ready_i,
   input  logic                    done_i,
   input  wb_dat_t                 rd_dat_i
);

   port_id_t             grant_q;
   port_id_t             pick;
   logic                 pick_any;
   logic                 locked_q;
   logic                 taken_q;
   logic [NUM_PORTS-1:0] ack_q;
   wb_dat_t              dat_q;

   // Lowest port number wins, a port in its ack cycle sits out
   always_comb begin
      pick_any = 1'b0;
      pick = '0;
      for (int p = NUM_PORTS - 1; p >= 0; p--) begin
         if (wbs_cyc_i[p] && wbs_stb_i[p] && !ack_q[p]) begin
            pick_any = 1'b1;
            pick = port_id_t'(p);
         end
      end
   end

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         grant_q <= '0;
         locked_q <= 1'b0;
         taken_q <= 1'b0;
         ack_q <= '0;
      end else begin
         ack_q <= '0;
         if (!locked_q) begin
            if (pick_any) begin
               grant_q <= pick;
               locked_q <= 1'b1;
            end
         end else if (done_i) begin
            // Single ack, then the grant is free again
            ack_q[grant_q] <= 1'b1;
            locked_q <= 1'b0;
            taken_q <= 1'b0;
         end else if (req_valid_o && req_ready_i) begin
            taken_q <= 1'b1;
         end
      end
   end

   // Read word held for the ack cycle
   always_ff @(posedge sdram_clk_0) begin
      if (done_i) begin
         dat_q <= rd_dat_i;
      end
   end

   // Master holds its inputs until ack, so the request is muxed live
   always_comb begin
      req_o.adr = wbs_adr_i[grant_q];
      req_o.we = wbs_we_i[grant_q];
      req_o.dat = wbs_dat_i[grant_q];
      req_o.sel = wbs_sel_i[grant_q];
   end

   assign req_valid_o = locked_q && !taken_q;
   assign wbs_ack_o = ack_q;
   // Same word on every port, qualified by that port's ack
   assign wbs_dat_o = {NUM_PORTS{dat_q}};

endmodule

//--- refresh_timer.sv
`timescale 1ns/1ns

module refresh_timer import sdram_pkg::*; (
   input  logic sdram_clk_0,
   input  logic wb_rst,
   input  logic ref_ack_i,
   output logic ref_req_o
);

   ref_cnt_t cnt_q;
   logic     cnt_zero;

   assign cnt_zero = (cnt_q == '0);

   // Interval down-counter
   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         cnt_q <= ref_cnt_t'(REF_INTERVAL);
      end else if (cnt_zero) begin
         cnt_q <= ref_cnt_t'(REF_INTERVAL);
      end else begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // Sticky request, one is already owed out of reset
   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         ref_req_o <= 1'b1;
      end else if (cnt_zero) begin
         ref_req_o <= 1'b1;
      end else if (ref_ack_i) begin
         ref_req_o <= 1'b0;
      end
   end

endmodule

//--- sdr_cmd_seq.sv
`timescale 1ns/1ns

module sdr_cmd_seq import sdram_pkg::*; (
   input  logic        sdram_clk_0,
   input  logic        wb_rst,
   input  mem_req_t    req_i,
   input  logic        req_valid_i,
   output logic        req_ready_o,
   output logic        done_o,
   output wb_dat_t     rd_dat_o,
   input  logic        ref_req_i,
   output logic        ref_ack_o,
   output sdram_pads_t pads_o,
   input  sdram_dq_t   dq_i
);

   typedef enum logic [3:0] {
      ST_INIT_WAIT,
      ST_INIT_PRE,
      ST_INIT_REF1,
      ST_INIT_REF2,
      ST_LMR,
      ST_IDLE,
      ST_ACT,
      ST_RCD_WAIT,
      ST_WR_HI,
      ST_WR_LO,
      ST_RD_HI,
      ST_RD_LO,
      ST_CAS_WAIT,
      ST_PRE,
      ST_RP_WAIT,
      ST_REF_WAIT
   } state_e;

   state_e                 state_q;
   state_e                 state_d;
   wait_cnt_t              cnt_q;
   wait_cnt_t              cnt_d;
   logic                   cnt_zero;
   logic                   take;
   mem_req_t               req_q;
   mem_req_t               cur_req;
   logic [COL_W-1:0]       col;
   sdram_ba_t              bank;
   sdram_adr_t             row;
   sdram_pads_t            pads_q;
   sdram_pads_t            pads_d;
   logic [CAS_LATENCY-1:0] rd_vld_q;
   logic [CAS_LATENCY-1:0] rd_lo_q;
   logic                   rd_done_q;

   // Word column then beat bit, A10 stays low so no auto precharge
   function automatic sdram_adr_t col_adr(input logic [COL_W-1:0] c, input logic beat);
      return sdram_adr_t'({c, beat});
   endfunction

   assign cnt_zero = (cnt_q == '0);
   assign req_ready_o = (state_q == ST_IDLE) && !ref_req_i;
   assign ref_ack_o = (state_q == ST_IDLE) && ref_req_i;
   assign take = req_ready_o && req_valid_i;

   // The request register is loaded on the same edge as ACT goes out
   assign cur_req = take ? req_i : req_q;
   assign col = cur_req.adr[COL_W-1:0];
   assign bank = cur_req.adr[COL_W +: BANK_W];
   assign row = cur_req.adr[COL_W + BANK_W +: ROW_W];

   assign done_o = (state_q == ST_RP_WAIT && cnt_zero && req_q.we) ||
                   (state_q == ST_CAS_WAIT && rd_done_q);

   always_comb begin
      state_d = state_q;
      cnt_d = cnt_zero ? cnt_q : cnt_q - 1'b1;
      case (state_q)
         ST_INIT_WAIT: begin
            if (cnt_zero) begin
               state_d = ST_INIT_PRE;
               cnt_d = wait_cnt_t'(T_RP - 1);
            end
         end
         ST_INIT_PRE: begin
            if (cnt_zero) begin
               state_d = ST_INIT_REF1;
               cnt_d = wait_cnt_t'(T_RFC - 1);
            end
         end
         ST_INIT_REF1: begin
            if (cnt_zero) begin
               state_d = ST_INIT_REF2;
               cnt_d = wait_cnt_t'(T_RFC - 1);
            end
         end
         ST_INIT_REF2: begin
            if (cnt_zero) begin
               state_d = ST_LMR;
            end
         end
         // Idle always lasts a cycle, which covers tMRD after LMR
         ST_LMR: state_d = ST_IDLE;
         ST_IDLE: begin
            if (ref_req_i) begin
               state_d = ST_REF_WAIT;
               cnt_d = wait_cnt_t'(T_RFC - 1);
            end else if (take) begin
               state_d = ST_ACT;
            end
         end
         ST_ACT: begin
            state_d = ST_RCD_WAIT;
            cnt_d = wait_cnt_t'(T_RCD - 2);
         end
         ST_RCD_WAIT: begin
            if (cnt_zero) begin
               state_d = req_q.we ? ST_WR_HI : ST_RD_HI;
            end
         end
         ST_WR_HI: state_d = ST_WR_LO;
         ST_WR_LO: state_d = ST_PRE;
         ST_RD_HI: state_d = ST_RD_LO;
         // Precharge goes out while read data is still in flight
         ST_RD_LO: state_d = ST_PRE;
         ST_PRE: begin
            state_d = ST_RP_WAIT;
            cnt_d = wait_cnt_t'(T_RP - 2);
         end
         ST_RP_WAIT: begin
            if (cnt_zero) begin
               state_d = req_q.we ? ST_IDLE : ST_CAS_WAIT;
            end
         end
         ST_CAS_WAIT: begin
            if (rd_done_q) begin
               state_d = ST_IDLE;
            end
         end
         ST_REF_WAIT: begin
            if (cnt_zero) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   // Command goes out in the first cycle of the state that owns it
   always_comb begin
      pads_d = PADS_IDLE;
      if (state_d != state_q) begin
         case (state_d)
            ST_INIT_PRE: begin
               pads_d.cmd = CMD_PRE;
               pads_d.a[10] = 1'b1;
            end
            ST_INIT_REF1, ST_INIT_REF2, ST_REF_WAIT: pads_d.cmd = CMD_REF;
            ST_LMR: begin
               pads_d.cmd = CMD_LMR;
               pads_d.a = MODE_WORD;
            end
            ST_ACT: begin
               pads_d.cmd = CMD_ACT;
               pads_d.ba = bank;
               pads_d.a = row;
            end
            ST_WR_HI, ST_WR_LO: begin
               pads_d.cmd = CMD_WRITE;
               pads_d.ba = bank;
               pads_d.a = col_adr(col, state_d == ST_WR_LO);
               pads_d.dq_oe = 1'b1;
               if (state_d == ST_WR_HI) begin
                  pads_d.dqm = ~cur_req.sel[3:2];
                  pads_d.dq_out = cur_req.dat[31:16];
               end else begin
                  pads_d.dqm = ~cur_req.sel[1:0];
                  pads_d.dq_out = cur_req.dat[15:0];
               end
            end
            ST_RD_HI, ST_RD_LO: begin
               pads_d.cmd = CMD_READ;
               pads_d.ba = bank;
               pads_d.a = col_adr(col, state_d == ST_RD_LO);
            end
            // Single bank, the others are already closed
            ST_PRE: begin
               pads_d.cmd = CMD_PRE;
               pads_d.ba = bank;
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge sdram_clk_0 or posedge wb_rst) begin
      if (wb_rst) begin
         state_q <= ST_INIT_WAIT;
         cnt_q <= wait_cnt_t'(INIT_WAIT);
         pads_q <= PADS_IDLE;
         rd_vld_q <= '0;
         rd_done_q <= 1'b0;
      end else begin
         state_q <= state_d;
         cnt_q <= cnt_d;
         pads_q <= pads_d;
         rd_vld_q <= {rd_vld_q[CAS_LATENCY-2:0], pads_q.cmd == CMD_READ};
         if (state_q == ST_IDLE) begin
            rd_done_q <= 1'b0;
         end else if (rd_vld_q[CAS_LATENCY-1] && rd_lo_q[CAS_LATENCY-1]) begin
            rd_done_q <= 1'b1;
         end
      end
   end

   // Beat bit of the READ tells which half the returning data fills
   always_ff @(posedge sdram_clk_0) begin
      rd_lo_q <= {rd_lo_q[CAS_LATENCY-2:0], pads_q.a[0]};
      if (take) begin
         req_q <= req_i;
      end
      if (rd_vld_q[CAS_LATENCY-1]) begin
         if (rd_lo_q[CAS_LATENCY-1]) begin
            rd_dat_o[15:0] <= dq_i;
         end else begin
            rd_dat_o[31:16] <= dq_i;
         end
      end
   end

   assign pads_o = pads_q;

endmodule

//--- sdram_ctrl_top.sv
`timescale 1ns/1ns

module sdram_ctrl_top import sdram_pkg::*; (
   input  logic                    sdram_clk_0,
   input  logic                    wb_rst,
   input  logic    [NUM_PORTS-1:0] wbs_cyc_i,
   input  logic    [NUM_PORTS-1:0] wbs_stb_i,
   input  logic    [NUM_PORTS-1:0] wbs_we_i,
   input  wb_adr_t [NUM_PORTS-1:0] wbs_adr_i,
   input  wb_dat_t [NUM_PORTS-1:0] wbs_dat_i,
   input  wb_sel_t [NUM_PORTS-1:0] wbs_sel_i,
   output logic    [NUM_PORTS-1:0] wbs_ack_o,
   output wb_dat_t [NUM_PORTS-1:0] wbs_dat_o,
   output sdram_pads_t             pads_o,
   input  sdram_dq_t               dq_i
);

   mem_req_t req;
   logic     req_valid;
   logic     req_ready;
   logic     done;
   wb_dat_t  rd_dat;
   logic     ref_req;
   logic     ref_ack;

   wb_port_arbiter u_arb (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .wbs_cyc_i   (wbs_cyc_i),
      .wbs_stb_i   (wbs_stb_i),
      .wbs_we_i    (wbs_we_i),
      .wbs_adr_i   (wbs_adr_i),
      .wbs_dat_i   (wbs_dat_i),
      .wbs_sel_i   (wbs_sel_i),
      .wbs_ack_o   (wbs_ack_o),
      .wbs_dat_o   (wbs_dat_o),
      .req_o       (req),
      .req_valid_o (req_valid),
      .req_ready_i (req_ready),
      .done_i      (done),
      .rd_dat_i    (rd_dat)
   );

   refresh_timer u_ref (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .ref_ack_i   (ref_ack),
      .ref_req_o   (ref_req)
   );

   sdr_cmd_seq u_seq (
      .sdram_clk_0 (sdram_clk_0),
      .wb_rst      (wb_rst),
      .req_i       (req),
      .req_valid_i (req_valid),
      .req_ready_o (req_ready),
      .done_o      (done),
      .rd_dat_o    (rd_dat),
      .ref_req_i   (ref_req),
      .ref_ack_o   (ref_ack),
      .pads_o      (pads_o),
      .dq_i        (dq_i)
   );

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
   output logic sdram_clk_o,
   output logic wb_rst_o
);

   initial begin
      sdram_clk_o = 1'b0;
      forever #5 sdram_clk_o = ~sdram_clk_o;
   end

   // Reset held for 8 cycles, released away from the rising edge
   initial begin
      wb_rst_o = 1'b1;
      repeat (8) @(posedge sdram_clk_o);
      @(negedge sdram_clk_o);
      wb_rst_o = 1'b0;
   end

endmodule

//--- tb_sdram_model.sv
`timescale 1ns/1ns

module tb_sdram_model import sdram_pkg::*; (
   input  logic        sdram_clk_0,
   input  sdram_pads_t pads_i,
   output sdram_dq_t   dq_o,
   output logic        viol_o
);

   sdram_dq_t  mem [logic [23:0]];
   sdram_dq_t  rd_pipe [CAS_LATENCY];
   logic [3:0] open_q = '0;
   sdram_adr_t open_row [4];
   int         act_cyc [4];
   int         cyc = 0;
   int         pre_cyc = -100;
   int         ref_cyc = -100;
   int         ref_cnt = 0;
   logic       pre_seen = 1'b0;
   logic       lmr_seen = 1'b0;

   initial viol_o = 1'b0;

   task automatic flag(input string msg);
      $display("SDRAM protocol broken at %0t: %s", $time, msg);
      viol_o = 1'b1;
   endtask

   assign dq_o = rd_pipe[CAS_LATENCY-1];

   always @(posedge sdram_clk_0) begin : cmd_check
      logic [23:0] key;
      sdram_dq_t   word;
      cyc++;
      key = {pads_i.ba, open_row[pads_i.ba], pads_i.a[8:0]};
      for (int i = CAS_LATENCY - 1; i > 0; i--) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
      rd_pipe[0] <= '0;
      if (pads_i.cmd != CMD_NOP) begin
         assert (cyc - pre_cyc >= T_RP) else flag("command inside tRP");
         assert (cyc - ref_cyc >= T_RFC) else flag("command inside tRFC");
      end
      // Longest allowed gap between refreshes
      if (ref_cnt > 0) begin
         assert (cyc - ref_cyc <= REF_INTERVAL + 60) else flag("refresh gap too long");
      end
      case (pads_i.cmd)
         CMD_ACT: begin
            assert (pre_seen && ref_cnt >= 2 && lmr_seen) else flag("ACT before init");
            assert (!open_q[pads_i.ba]) else flag("ACT to an open bank");
            open_q[pads_i.ba] = 1'b1;
            open_row[pads_i.ba] = pads_i.a;
            act_cyc[pads_i.ba] = cyc;
         end
         CMD_WRITE, CMD_READ: begin
            assert (open_q[pads_i.ba]) else flag("column command to a closed bank");
            assert (cyc - act_cyc[pads_i.ba] >= T_RCD) else flag("column command inside tRCD");
            word = mem.exists(key) ? mem[key] : '0;
            if (pads_i.cmd == CMD_WRITE) begin
               assert (pads_i.dq_oe) else flag("WRITE without data drive");
               // dqm bit high masks its byte
               if (!pads_i.dqm[0]) begin
                  word[7:0] = pads_i.dq_out[7:0];
               end
               if (!pads_i.dqm[1]) begin
                  word[15:8] = pads_i.dq_out[15:8];
               end
               mem[key] = word;
            end else begin
               rd_pipe[0] <= word;
            end
         end
         CMD_PRE: begin
            if (pads_i.a[10]) begin
               open_q = '0;
            end else begin
               open_q[pads_i.ba] = 1'b0;
            end
            pre_cyc = cyc;
            pre_seen = 1'b1;
         end
         CMD_REF: begin
            assert (open_q == '0) else flag("REF with a bank open");
            ref_cyc = cyc;
            ref_cnt++;
         end
         CMD_LMR: begin
            // Single-beat bursts in sequential order, CAS latency in A6 to A4
            assert (pads_i.a[2:0] == 3'b000 && !pads_i.a[3] &&
                    pads_i.a[6:4] == 3'(CAS_LATENCY) && pads_i.a[12:7] == '0)
               else flag("wrong mode word");
            assert (pre_seen && ref_cnt >= 2) else flag("LMR before precharge and refreshes");
            lmr_seen = 1'b1;
         end
         default: ;
      endcase
   end

endmodule

//--- tb_sdram_ctrl.sv
`timescale 1ns/1ns

module tb_sdram_ctrl import sdram_pkg::*; ();

   localparam int N_WORDS = 8;
   localparam int ARB_ROUNDS = 4;
   localparam int IDLE_CYCLES = 1000;
   localparam int N_TXN = 2 * 3 * N_WORDS + 4 * ARB_ROUNDS + 1;
   localparam int CYCLE_LIMIT = N_TXN * 60 + INIT_WAIT + 500;

   logic                    clk;
   logic                    rst;
   logic    [NUM_PORTS-1:0] cyc_i;
   logic    [NUM_PORTS-1:0] stb_i;
   logic    [NUM_PORTS-1:0] we_i;
   wb_adr_t [NUM_PORTS-1:0] adr_i;
   wb_dat_t [NUM_PORTS-1:0] dat_i;
   wb_sel_t [NUM_PORTS-1:0] sel_i;
   logic    [NUM_PORTS-1:0] ack_o;
   wb_dat_t [NUM_PORTS-1:0] dat_o;
   sdram_pads_t             pads;
   sdram_dq_t               dq;
   logic                    viol;
   logic    [NUM_PORTS-1:0] ack_prev = '0;
   logic    [7:0]           sb_mem [logic [31:0]];
   int                      seed = 32'hb1b9dab6;
   int                      cycles = 0;
   int                      fin_seq = 0;

   tb_clk_gen u_clk (.sdram_clk_o(clk), .wb_rst_o(rst));

   sdram_ctrl_top uut (
      .sdram_clk_0 (clk),
      .wb_rst      (rst),
      .wbs_cyc_i   (cyc_i),
      .wbs_stb_i   (stb_i),
      .wbs_we_i    (we_i),
      .wbs_adr_i   (adr_i),
      .wbs_dat_i   (dat_i),
      .wbs_sel_i   (sel_i),
      .wbs_ack_o   (ack_o),
      .wbs_dat_o   (dat_o),
      .pads_o      (pads),
      .dq_i        (dq)
   );

   tb_sdram_model u_mem (.sdram_clk_0(clk), .pads_i(pads), .dq_o(dq), .viol_o(viol));

   task automatic value_error(input string msg);
      $display("FAILED at %0t: %s", $time, msg);
      $display("ERRORS FOUND");
      $fatal(1, "wrong value");
   endtask

   task automatic protocol_error(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "protocol error");
   endtask

   // Expected word built from the byte mirror
   function automatic wb_dat_t sb_word(input wb_adr_t a);
      wb_dat_t w;
      w = '0;
      for (int l = 0; l < 4; l++) begin
         if (sb_mem.exists({a, 2'(l)})) begin
            w[l*8 +: 8] = sb_mem[{a, 2'(l)}];
         end
      end
      return w;
   endfunction

   // Single Wishbone classic cycle on port p
   task automatic wb_access(input int p, input logic we, input wb_adr_t a,
                            input wb_dat_t d, input wb_sel_t s, output wb_dat_t rdat);
      @(negedge clk);
      cyc_i[p] = 1'b1;
      stb_i[p] = 1'b1;
      we_i[p] = we;
      adr_i[p] = a;
      dat_i[p] = d;
      sel_i[p] = s;
      do @(posedge clk); while (!ack_o[p]);
      rdat = dat_o[p];
      @(negedge clk);
      cyc_i[p] = 1'b0;
      stb_i[p] = 1'b0;
      if (we) begin
         for (int l = 0; l < 4; l++) begin
            if (s[l]) begin
               sb_mem[{a, 2'(l)}] = d[l*8 +: 8];
            end
         end
      end
   endtask

   task automatic read_check(input int p, input wb_adr_t a);
      wb_dat_t rdat;
      wb_dat_t exp;
      exp = sb_word(a);
      wb_access(p, 1'b0, a, '0, 4'hf, rdat);
      assert (rdat === exp) else
         value_error($sformatf("port %0d adr %h read %h expected %h", p, a, rdat, exp));
   endtask

   // Each ack lasts one cycle and needs a strobe
   always @(negedge clk) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (ack_o[p]) begin
            assert (cyc_i[p] && stb_i[p]) else protocol_error("ack arrived without strobe");
            assert (!ack_prev[p]) else protocol_error("ack held for more than one cycle");
         end
      end
      ack_prev <= ack_o;
   end

   always @(posedge viol) begin
      $display("ERRORS FOUND");
      $fatal(1, "SDRAM model reported a violation");
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles", cycles);
         $display("ERRORS FOUND");
         $fatal(1, "timeout");
      end
   end

   initial begin : stim
      wb_adr_t adrs [NUM_PORTS][N_WORDS];
      wb_adr_t a0;
      wb_dat_t d0;
      wb_dat_t d1;
      wb_dat_t rdat;
      int      fin [NUM_PORTS];
      cyc_i = '0;
      stb_i = '0;
      we_i = '0;
      adr_i = '0;
      dat_i = '0;
      sel_i = '0;
      @(negedge clk);
      while (rst) begin
         assert (ack_o == '0) else value_error("ack high during reset");
         assert (pads.cmd == CMD_NOP && !pads.dq_oe) else value_error("pads busy in reset");
         @(negedge clk);
      end

      // Full writes, partial writes, then read back per port
      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int i = 0; i < N_WORDS; i++) begin
            adrs[p][i] = wb_adr_t'($random(seed)) & 30'h007f_ffff;
            wb_access(p, 1'b1, adrs[p][i], $random(seed), 4'hf, rdat);
         end
         for (int i = 0; i < N_WORDS; i++) begin
            wb_access(p, 1'b1, adrs[p][i], $random(seed), wb_sel_t'($random(seed)), rdat);
         end
         for (int i = 0; i < N_WORDS; i++) begin
            read_check(p, adrs[p][i]);
         end
      end

      // Both ports strobe in the same cycle
      for (int r = 0; r < ARB_ROUNDS; r++) begin
         a0 = wb_adr_t'($random(seed)) & 30'h007f_fffe;
         d0 = $random(seed);
         d1 = $random(seed);
         fork
            begin
               wb_dat_t r0;
               wb_access(0, 1'b1, a0, d0, 4'hf, r0);
               fin[0] = ++fin_seq;
            end
            begin
               wb_dat_t r1;
               wb_access(1, 1'b1, a0 | 30'h1, d1, 4'hf, r1);
               fin[1] = ++fin_seq;
            end
         join
         assert (fin[0] < fin[1]) else value_error("port 1 acked before port 0");
         fork
            begin
               read_check(0, a0);
               fin[0] = ++fin_seq;
            end
            begin
               read_check(1, a0 | 30'h1);
               fin[1] = ++fin_seq;
            end
         join
         assert (fin[0] < fin[1]) else value_error("port 1 read acked before port 0");
      end

      // Refresh keeps running while the bus is quiet
      repeat (IDLE_CYCLES) @(negedge clk);
      read_check(1, adrs[0][0]);

      $display("NO ERRORS");
      $finish;
   end

endmodule

//--- list.f
sdram_pkg.sv
wb_port_arbiter.sv
refresh_timer.sv
sdr_cmd_seq.sv
sdram_ctrl_top.sv
tb_clk_gen.sv
tb_sdram_model.sv
tb_sdram_ctrl.sv

//--- Makefile
TOP := tb_sdram_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f list.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
